//--- project.f
+incdir+tb
src/dhcp_pkg.sv
src/dhcp_opt_assembler.sv
src/dhcp_ipv4_id_lfsr.sv
src/dhcp_frame_serializer.sv
src/dhcp_tx_top.sv
tb/dhcp_tx_tb.sv

//--- tb/dhcp_tx_checks.svh
`ifndef DHCP_TX_CHECKS_SVH
`define DHCP_TX_CHECKS_SVH

byte_t exp_bytes[$];  // expected payload of the current packet

////////////////////////////////////////////////////////////
// reference model
////////////////////////////////////////////////////////////

function automatic logic [31:0] lfsr_step(logic [31:0] s);
  return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // galois, right shift
endfunction

// top n bytes of v, msb first
function automatic void push_vec(logic [127:0] v, int n);
  for (int i = 0; i < n; i++) begin
    exp_bytes.push_back(v[127 - 8 * i -: 8]);
  end
endfunction

function automatic void build_expected(dhcp_req_t r);
  logic [127:0] slot [0:5];  // code, len, value, pad
  slot[0] = {8'd53, 8'd1, r.msg_type, 104'd0};
  slot[1] = {8'd50, 8'd4, r.req_ip, 80'd0};
  slot[2] = {8'd61, 8'd7, 8'd1, r.chaddr, 56'd0};  // htype + mac
  slot[3] = {8'd12, 8'(HOST_LEN), (112'(HOST_STR) << (112 - 8 * HOST_LEN))};
  slot[4] = {8'd15, 8'(DOMAIN_LEN), (112'(DOMAIN_STR) << (112 - 8 * DOMAIN_LEN))};
  slot[5] = {8'd81, 8'(FQDN_NAME_LEN), (112'(FQDN_STR) << (112 - 8 * FQDN_NAME_LEN))};
  exp_bytes.delete();
  push_vec({8'd1, 8'd1, 8'd6, 8'd0, r.xid, 16'd0, 16'h8000, r.ciaddr}, 16);  // op..ciaddr
  push_vec(128'd0, 12);                // yiaddr, siaddr, giaddr
  push_vec({r.chaddr, 80'd0}, 16);     // chaddr, zero padded
  for (int i = 0; i < 12; i++) begin
    push_vec(128'd0, 16);              // sname + file, 192 bytes
  end
  push_vec({32'h6382_5363, 96'd0}, 4); // magic cookie
  for (int s = 0; s < 6; s++) begin
    if (r.opt_pres[s]) begin
      push_vec(slot[s], 16);           // compacted, presence order
    end
  end
  push_vec({8'd255, 120'd0}, 16);      // end slot always last
endfunction

function automatic udp_meta_t model_meta(dhcp_req_t r, len_t olen, logic [31:0] lfsr);
  udp_meta_t m;
  m.src_port = 16'd68;
  m.dst_port = 16'd67;
  m.length   = len_t'(240 + 8) + olen;  // payload + udp header
  m.cks      = 16'd0;
  m.src_ip   = r.src_ip;
  m.dst_ip   = r.dst_ip;
  m.ipv4_id  = lfsr[15:0];
  m.dst_mac  = 48'hffff_ffff_ffff;
  return m;
endfunction

////////////////////////////////////////////////////////////
// compare tasks
////////////////////////////////////////////////////////////

task automatic compare_byte(string name, byte_t exp, byte_t act);
  if (act !== exp) begin
    fail_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
  end
endtask

task automatic compare_len(string name, len_t exp, len_t act);
  if (act !== exp) begin
    fail_run($sformatf("Mismatch %s: expected %0d, actual %0d", name, exp, act));
  end
endtask

task automatic compare_meta(string name, udp_meta_t exp, udp_meta_t act);
  if (act !== exp) begin
    fail_run($sformatf("Mismatch %s meta: expected %h, actual %h", name, exp, act));
  end
endtask

`endif

//--- tb/dhcp_tx_tb.sv
`timescale 1ns/1ps

module dhcp_tx_tb;
  import dhcp_pkg::*;

  localparam int HOST_LEN      = 8;
  localparam int DOMAIN_LEN    = 7;
  localparam int FQDN_NAME_LEN = 11;
  localparam logic [0:HOST_LEN-1][7:0]      HOST_STR   = "localnya";
  localparam logic [0:DOMAIN_LEN-1][7:0]    DOMAIN_STR = "nya.com";
  localparam logic [0:FQDN_NAME_LEN-1][7:0] FQDN_STR   = "www.nya.com";
  localparam int NUM_TESTS       = 5;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * (HDR_TOT_LEN_TX * 4 + 100);

  logic        clk;
  logic        fsm_rst;
  logic        req_val;
  dhcp_req_t   req;
  logic        busy;
  logic        udp_req;
  logic        udp_rdy;
  udp_meta_t   udp_meta;
  udp_strm_t   udp_strm;
  byte_t       rx_bytes[$];       // collected beats
  int          eof_cnt;
  int          eof_pos;           // index of last eof beat
  logic        mon_en;
  logic        prev_fire;         // beat owed on this edge
  logic [31:0] exp_lfsr;          // model id generator
  udp_meta_t   last_meta;
  integer      seed = 32'h9cf2_da4d;

  task automatic fail_run(string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "run stopped at the first error");
  endtask

  `include "dhcp_tx_checks.svh"

  dhcp_tx_top #(
    .DOMAIN_NAME_LEN (DOMAIN_LEN),
    .HOSTNAME_LEN    (HOST_LEN),
    .FQDN_LEN        (FQDN_NAME_LEN),
    .DOMAIN_NAME     (DOMAIN_STR),
    .HOSTNAME        (HOST_STR),
    .FQDN            (FQDN_STR)
  ) dhcp_tx_top_i (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .req_val  (req_val),
    .req      (req),
    .busy     (busy),
    .udp_req  (udp_req),
    .udp_rdy  (udp_rdy),
    .udp_meta (udp_meta),
    .udp_strm (udp_strm)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    fail_run("watchdog expired before all tests finished");
  end

  ////////////////////////////////////////////////////////////
  // stream collector
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (mon_en) begin
      if (udp_strm.val !== prev_fire) begin
        fail_run(prev_fire ? "no beat after a sampled udp_req" :
                             "beat without a sampled udp_req");
      end
      if (udp_strm.val) begin
        if (udp_strm.sof !== (rx_bytes.size() == 0)) begin
          fail_run("sof is not on the first beat of the packet only");
        end
        rx_bytes.push_back(udp_strm.dat);
        if (udp_strm.eof) begin
          eof_cnt++;
          eof_pos = rx_bytes.size() - 1;
        end
      end
    end
    // eof cycle swallows udp_req, reset cancels it
    prev_fire = mon_en && udp_req && udp_rdy && !udp_strm.eof && !fsm_rst;
  end

  ////////////////////////////////////////////////////////////
  // drivers
  ////////////////////////////////////////////////////////////

  task automatic apply_reset();
    fsm_rst = 1'b1;
    req_val = 1'b0;
    udp_req = 1'b0;
    repeat (16) @(negedge clk);
    fsm_rst  = 1'b0;
    exp_lfsr = 32'h0000_0001;  // id generator restarts
  endtask

  function automatic dhcp_req_t make_req(byte_t mt, xid_t xid, opt_pres_t pres);
    dhcp_req_t r;
    r.msg_type = mt;
    r.xid      = xid;
    r.chaddr   = 48'h02_00_5e_10_20_30;
    r.ciaddr   = 32'hc0a8_0105;
    r.req_ip   = 32'hc0a8_0164;
    r.src_ip   = xid ^ 32'h0a00_0000;  // varies per packet
    r.dst_ip   = 32'hffff_ffff;
    r.opt_pres = pres;
    return r;
  endfunction

  task automatic send_request(dhcp_req_t r);
    @(negedge clk);
    req     = r;
    req_val = 1'b1;
    @(negedge clk);
    req_val = 1'b0;
    req     = '0;  // must be latched by now
    if (!busy) begin
      fail_run("busy did not rise after req_val");
    end
  endtask

  task automatic run_packet(string name, dhcp_req_t r, bit gaps);
    int          eof_base;
    int          eof_prev;  // eof count before the last edge
    int          waited;
    logic [31:0] rnd;
    len_t        olen;
    build_expected(r);
    olen = len_t'(exp_bytes.size() - DHCP_HDR_LEN);
    rx_bytes.delete();
    eof_base = eof_cnt;
    send_request(r);
    waited = 0;
    while (!udp_rdy) begin
      if (waited > 4 * OPT_NUM_TX) begin
        fail_run("udp_rdy did not rise after the request");
      end
      waited++;
      @(negedge clk);
    end
    last_meta = udp_meta;
    compare_meta(name, model_meta(r, olen, exp_lfsr), udp_meta);
    eof_prev = eof_cnt;
    while (busy) begin
      eof_prev = eof_cnt;
      rnd      = $random(seed);
      udp_req  = gaps ? rnd[0] : 1'b1;
      @(negedge clk);
    end
    udp_req = 1'b0;
    compare_len({name, " eof count"}, 16'd1, len_t'(eof_cnt - eof_base));
    compare_len({name, " stream length"}, len_t'(exp_bytes.size()), len_t'(rx_bytes.size()));
    compare_len({name, " eof position"}, len_t'(exp_bytes.size() - 1), len_t'(eof_pos));
    if (eof_cnt == eof_prev || udp_rdy) begin
      fail_run("busy or udp_rdy did not fall one cycle after the eof beat");
    end
    for (int i = 0; i < exp_bytes.size(); i++) begin
      compare_byte($sformatf("%s byte %0d", name, i), exp_bytes[i], rx_bytes[i]);
    end
    exp_lfsr = lfsr_step(exp_lfsr);  // one step per sent packet
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////

  task automatic discover_all_options();
    run_packet("discover_all", make_req(DHCP_MSG_DISCOVER, 32'h1a2b_3c4d, 6'b11_1111), 1'b0);
    compare_len("discover_all udp length", 16'd360, last_meta.length);
  endtask

  task automatic request_sparse_mask();
    run_packet("request_sparse", make_req(DHCP_MSG_REQUEST, 32'h5566_7788, 6'b10_0011), 1'b0);
    compare_len("request_sparse opt_len", 16'd64, len_t'(rx_bytes.size() - DHCP_HDR_LEN));
    compare_len("request_sparse udp length", 16'd312, last_meta.length);
  endtask

  task automatic random_req_gaps();
    run_packet("random_gaps", make_req(DHCP_MSG_DISCOVER, 32'h1a2b_3c4d, 6'b11_1111), 1'b1);
  endtask

  task automatic ipv4_id_sequence();
    apply_reset();
    for (int k = 0; k < 3; k++) begin
      run_packet($sformatf("ipv4_id pkt %0d", k),
                 make_req(DHCP_MSG_REQUEST, 32'h0000_1000 + k, 6'b00_0111), 1'b0);
    end
  endtask

  task automatic reset_mid_stream();
    int eof_base;
    eof_base = eof_cnt;
    rx_bytes.delete();
    send_request(make_req(DHCP_MSG_REQUEST, 32'h0bad_cafe, 6'b11_1111));
    udp_req = 1'b1;
    while (rx_bytes.size() < 100) @(negedge clk);  // well inside the header
    apply_reset();
    if (udp_rdy || udp_strm.val || busy) begin
      fail_run("udp_rdy, val or busy still high after fsm_rst mid-stream");
    end
    compare_len("reset_mid_stream eof count", 16'd0, len_t'(eof_cnt - eof_base));
    run_packet("reset_mid_stream restart",
               make_req(DHCP_MSG_REQUEST, 32'h0bad_cafe, 6'b11_1111), 1'b0);
  endtask

  initial begin
    fsm_rst   = 1'b1;
    req_val   = 1'b0;
    req       = '0;
    udp_req   = 1'b0;
    mon_en    = 1'b0;
    prev_fire = 1'b0;
    eof_cnt   = 0;
    eof_pos   = 0;
    apply_reset();
    mon_en = 1'b1;
    discover_all_options();
    request_sparse_mask();
    random_req_gaps();
    ipv4_id_sequence();
    reset_mid_stream();
    $display("Simulation passed");
    $finish;
  end

endmodule

//--- src/dhcp_tx_top.sv
`timescale 1ns/1ps

module dhcp_tx_top #(
  parameter int unsigned                     DOMAIN_NAME_LEN = 7,
  parameter int unsigned                     HOSTNAME_LEN    = 8,
  parameter int unsigned                     FQDN_LEN        = 11,
  parameter logic [0:DOMAIN_NAME_LEN-1][7:0] DOMAIN_NAME     = "nya.com",
  parameter logic [0:HOSTNAME_LEN-1][7:0]    HOSTNAME        = "localnya",
  parameter logic [0:FQDN_LEN-1][7:0]        FQDN            = "www.nya.com"
) (
  input  logic                clk,
  input  logic                fsm_rst,
  input  logic                req_val,
  input  dhcp_pkg::dhcp_req_t req,
  output logic                busy,
  input  logic                udp_req,
  output logic                udp_rdy,
  output dhcp_pkg::udp_meta_t udp_meta,
  output dhcp_pkg::udp_strm_t udp_strm
);
  import dhcp_pkg::*;

  opt_area_t   opt_area;  // compacted option slots
  len_t        opt_len;
  logic        opt_rdy;
  logic        pkt_done;  // eof beat, clears the datapath
  logic [15:0] ipv4_id;

  dhcp_opt_assembler #(
    .DOMAIN_NAME_LEN (DOMAIN_NAME_LEN),
    .HOSTNAME_LEN    (HOSTNAME_LEN),
    .FQDN_LEN        (FQDN_LEN),
    .DOMAIN_NAME     (DOMAIN_NAME),
    .HOSTNAME        (HOSTNAME),
    .FQDN            (FQDN)
  ) dhcp_opt_assembler_i (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .req_val  (req_val),
    .req      (req),
    .pkt_done (pkt_done),
    .opt_area (opt_area),
    .opt_len  (opt_len),
    .opt_rdy  (opt_rdy)
  );

  dhcp_frame_serializer dhcp_frame_serializer_i (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .req_val  (req_val),
    .req      (req),
    .opt_area (opt_area),
    .opt_len  (opt_len),
    .opt_rdy  (opt_rdy),
    .ipv4_id  (ipv4_id),
    .udp_req  (udp_req),
    .udp_rdy  (udp_rdy),
    .udp_meta (udp_meta),
    .udp_strm (udp_strm),
    .busy     (busy),
    .pkt_done (pkt_done)
  );

  dhcp_ipv4_id_lfsr dhcp_ipv4_id_lfsr_i (
    .clk     (clk),
    .fsm_rst (fsm_rst),   // id sequence only restarts on hard reset
    .step    (pkt_done),
    .ipv4_id (ipv4_id)
  );

endmodule

//--- src/dhcp_frame_serializer.sv
`timescale 1ns/1ps

module dhcp_frame_serializer (
  input  logic                clk,
  input  logic                fsm_rst,
  input  logic                req_val,
  input  dhcp_pkg::dhcp_req_t req,
  input  dhcp_pkg::opt_area_t opt_area,
  input  dhcp_pkg::len_t      opt_len,
  input  logic                opt_rdy,
  input  logic [15:0]         ipv4_id,
  input  logic                udp_req,
  output logic                udp_rdy,
  output dhcp_pkg::udp_meta_t udp_meta,
  output dhcp_pkg::udp_strm_t udp_strm,
  output logic                busy,
  output logic                pkt_done
);
  import dhcp_pkg::*;

  typedef enum logic [1:0] {
    SER_IDLE,      // waiting for a request
    SER_WAIT_OPT,  // header latched, options being built
    SER_SEND       // packet ready, shifting on udp_req
  } ser_state_t;

  ser_state_t                     state;
  logic                           clr;
  logic                           ld_opt;     // options arrive this cycle
  logic                           emit;       // one beat next cycle
  logic                           last_beat;
  dhcp_hdr_t                      hdr_fix;    // header built from req
  logic [0:HDR_TOT_LEN_TX-1][7:0] frame_sr;   // byte 0 goes out first
  len_t                           byte_cnt;   // beats sent so far
  len_t                           last_idx;   // index of the eof byte
  byte_t                          strm_dat;
  logic                           strm_val;
  logic                           strm_sof;
  logic                           strm_eof;

  ////////////////////////////////////////////////////////////
  // fixed header
  ////////////////////////////////////////////////////////////

  always_comb begin
    hdr_fix        = '0;  // hops, secs, y/s/giaddr, sname, file
    hdr_fix.op     = DHCP_OP_BOOTREQUEST;
    hdr_fix.htype  = DHCP_HTYPE_ETH;
    hdr_fix.hlen   = DHCP_HLEN_ETH;
    hdr_fix.xid    = req.xid;
    hdr_fix.flags  = DHCP_FLAGS_BCAST;
    hdr_fix.ciaddr = req.ciaddr;
    hdr_fix.chaddr = {req.chaddr, 80'd0};  // mac left aligned in 16 bytes
    hdr_fix.cookie = DHCP_MAGIC_COOKIE;
  end

  ////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////

  assign clr       = fsm_rst | pkt_done;  // self clear after eof
  assign ld_opt    = (state == SER_WAIT_OPT) && opt_rdy;
  assign emit      = (state == SER_SEND) && udp_req && !pkt_done;
  assign last_beat = (byte_cnt == last_idx);

  always_ff @(posedge clk) begin
    if (clr) begin
      state    <= SER_IDLE;
      byte_cnt <= '0;
      strm_val <= 1'b0;
      strm_sof <= 1'b0;
      strm_eof <= 1'b0;
      pkt_done <= 1'b0;
    end else begin
      strm_val <= emit;
      strm_sof <= emit && (byte_cnt == '0);
      strm_eof <= emit && last_beat;
      pkt_done <= emit && last_beat;  // same cycle as eof beat
      if (req_val) begin
        state    <= SER_WAIT_OPT;
        byte_cnt <= '0;
      end else if (ld_opt) begin
        state <= SER_SEND;
      end else if (emit) begin
        byte_cnt <= byte_cnt + 1'b1;
      end
    end
  end

  assign busy    = (state != SER_IDLE);
  assign udp_rdy = (state == SER_SEND);

  ////////////////////////////////////////////////////////////
  // frame and metadata
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (req_val) begin
      frame_sr[0:DHCP_HDR_LEN-1] <= hdr_fix;
      udp_meta.src_ip            <= req.src_ip;  // req only valid with the strobe
      udp_meta.dst_ip            <= req.dst_ip;
    end else if (ld_opt) begin
      frame_sr[DHCP_HDR_LEN:HDR_TOT_LEN_TX-1] <= opt_area;  // options behind header
      last_idx          <= len_t'(DHCP_HDR_LEN) + opt_len - 1'b1;
      udp_meta.src_port <= DHCP_CLI_PORT;
      udp_meta.dst_port <= DHCP_SRV_PORT;
      udp_meta.length   <= len_t'(DHCP_HDR_LEN + UDP_HDR_LEN) + opt_len;
      udp_meta.cks      <= '0;  // checksum not computed
      udp_meta.ipv4_id  <= ipv4_id;
      udp_meta.dst_mac  <= MAC_BROADCAST;
    end else if (emit) begin
      strm_dat                   <= frame_sr[0];
      frame_sr[0:HDR_TOT_LEN_TX-2] <= frame_sr[1:HDR_TOT_LEN_TX-1];  // holds without udp_req
    end
  end

  always_comb begin
    udp_strm.dat = strm_dat;
    udp_strm.val = strm_val;
    udp_strm.sof = strm_sof;
    udp_strm.eof = strm_eof;
  end

  // controller must wait for the previous packet
  no_req_busy_a : assert property (@(posedge clk) disable iff (fsm_rst)
    req_val |-> !busy);

  // a beat only answers a request seen while ready
  val_after_rdy_a : assert property (@(posedge clk) disable iff (fsm_rst)
    udp_strm.val |-> $past(udp_rdy));

  eof_val_a : assert property (@(posedge clk) disable iff (fsm_rst)
    udp_strm.eof |-> udp_strm.val);

endmodule

//--- src/dhcp_ipv4_id_lfsr.sv
`timescale 1ns/1ps

module dhcp_ipv4_id_lfsr (
  input  logic        clk,
  input  logic        fsm_rst,
  input  logic        step,     // one pulse per sent packet
  output logic [15:0] ipv4_id
);
  import dhcp_pkg::*;

  logic [31:0] lfsr;
  logic [31:0] lfsr_nxt;

  ////////////////////////////////////////////////////////////
  // galois form, shifting right
  ////////////////////////////////////////////////////////////

  always_comb begin
    lfsr_nxt = lfsr >> 1;
    if (lfsr[0]) begin
      lfsr_nxt = lfsr_nxt ^ LFSR_TAPS;  // dropped bit feeds the taps
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      lfsr <= LFSR_SEED;
    end else if (step) begin
      lfsr <= lfsr_nxt;
    end
  end

  assign ipv4_id = lfsr[15:0];  // low half is the id

  // all-zero state would lock the generator
  lfsr_nonzero_a : assert property (@(posedge clk) disable iff (fsm_rst)
    lfsr != '0);

endmodule

//--- src/dhcp_opt_assembler.sv
`timescale 1ns/1ps

module dhcp_opt_assembler #(
  parameter int unsigned                     DOMAIN_NAME_LEN = 7,
  parameter int unsigned                     HOSTNAME_LEN    = 8,
  parameter int unsigned                     FQDN_LEN        = 11,
  parameter logic [0:DOMAIN_NAME_LEN-1][7:0] DOMAIN_NAME     = "nya.com",
  parameter logic [0:HOSTNAME_LEN-1][7:0]    HOSTNAME        = "localnya",
  parameter logic [0:FQDN_LEN-1][7:0]        FQDN            = "www.nya.com"
) (
  input  logic                clk,
  input  logic                fsm_rst,
  input  logic                req_val,
  input  dhcp_pkg::dhcp_req_t req,
  input  logic                pkt_done,
  output dhcp_pkg::opt_area_t opt_area,
  output dhcp_pkg::len_t      opt_len,
  output logic                opt_rdy
);
  import dhcp_pkg::*;

  localparam int CNT_W = $clog2(OPT_NUM_TX + 1);

  typedef enum logic [1:0] {
    ASM_IDLE,   // nothing loaded
    ASM_SHIFT,  // walking the slots
    ASM_HOLD    // option area valid until pkt_done
  } asm_state_t;

  asm_state_t            state;
  logic                  clr;
  logic [CNT_W-1:0]      step_cnt;  // slots inspected so far
  logic [CNT_W-1:0]      wr_ptr;    // next free slot in opt_area
  logic [OPT_NUM_TX-1:0] pres_sr;   // presence, end slot on top
  opt_area_t             proto_ld;  // prototypes built from req
  opt_area_t             proto_sr;  // prototypes being shifted

  ////////////////////////////////////////////////////////////
  // slot prototypes
  ////////////////////////////////////////////////////////////

  always_comb begin
    proto_ld[0] = {DHCP_OPT_MESSAGE_TYPE, byte_t'(DHCP_OPT_MESSAGE_TYPE_LEN),
                   req.msg_type,
                   {(OPT_LEN - DHCP_OPT_MESSAGE_TYPE_LEN - 2){DHCP_OPT_PAD}}};
    proto_ld[1] = {DHCP_OPT_REQUESTED_IP_ADDRESS, byte_t'(DHCP_OPT_REQUESTED_IP_ADDRESS_LEN),
                   req.req_ip,
                   {(OPT_LEN - DHCP_OPT_REQUESTED_IP_ADDRESS_LEN - 2){DHCP_OPT_PAD}}};
    proto_ld[2] = {DHCP_OPT_DHCP_CLIENT_ID, byte_t'(DHCP_OPT_DHCP_CLIENT_ID_LEN),
                   DHCP_HTYPE_ETH, req.chaddr,  // client id = htype + mac
                   {(OPT_LEN - DHCP_OPT_DHCP_CLIENT_ID_LEN - 2){DHCP_OPT_PAD}}};
    proto_ld[3] = {DHCP_OPT_HOSTNAME, byte_t'(HOSTNAME_LEN), HOSTNAME,
                   {(OPT_LEN - HOSTNAME_LEN - 2){DHCP_OPT_PAD}}};
    proto_ld[4] = {DHCP_OPT_DOMAIN_NAME, byte_t'(DOMAIN_NAME_LEN), DOMAIN_NAME,
                   {(OPT_LEN - DOMAIN_NAME_LEN - 2){DHCP_OPT_PAD}}};
    proto_ld[5] = {DHCP_OPT_FULLY_QUALIFIED_DOMAIN_NAME, byte_t'(FQDN_LEN), FQDN,
                   {(OPT_LEN - FQDN_LEN - 2){DHCP_OPT_PAD}}};
    proto_ld[6] = {DHCP_OPT_END, {(OPT_LEN - 1){DHCP_OPT_PAD}}};  // always sent
  end

  ////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////

  assign clr = fsm_rst | pkt_done;  // packet sent or hard reset

  always_ff @(posedge clk) begin
    if (clr) begin
      state    <= ASM_IDLE;
      step_cnt <= '0;
      wr_ptr   <= '0;
      pres_sr  <= '0;
      opt_len  <= '0;
      opt_rdy  <= 1'b0;
    end else begin
      opt_rdy <= 1'b0;  // single pulse
      if (req_val) begin
        state    <= ASM_SHIFT;
        step_cnt <= '0;
        wr_ptr   <= '0;
        opt_len  <= '0;
        pres_sr  <= {1'b1, req.opt_pres};  // end slot forced present
      end else if (state == ASM_SHIFT) begin
        step_cnt <= step_cnt + 1'b1;
        pres_sr  <= pres_sr >> 1;
        if (pres_sr[0]) begin
          wr_ptr  <= wr_ptr + 1'b1;
          opt_len <= opt_len + len_t'(OPT_LEN);
        end
        if (step_cnt == CNT_W'(OPT_NUM_TX - 1)) begin  // last slot handled now
          state   <= ASM_HOLD;
          opt_rdy <= 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // slot compaction
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (req_val) begin
      proto_sr <= proto_ld;
      opt_area <= '0;  // unused slots read as pad
    end else if (state == ASM_SHIFT) begin
      proto_sr[0:OPT_NUM_TX-2] <= proto_sr[1:OPT_NUM_TX-1];  // next slot to front
      if (pres_sr[0]) begin
        opt_area[wr_ptr] <= proto_sr[0];  // present slots packed to the front
      end
    end
  end

  // names plus code and length byte must fit a slot
  name_fit_a : assert property (@(posedge clk)
    (DOMAIN_NAME_LEN + 2 <= OPT_LEN) &&
    (HOSTNAME_LEN + 2 <= OPT_LEN) &&
    (FQDN_LEN + 2 <= OPT_LEN));

endmodule

//--- src/dhcp_pkg.sv
package dhcp_pkg;

  ////////////////////////////////////////////////////////////
  // plain vector types
  ////////////////////////////////////////////////////////////

  typedef logic [7:0]  byte_t;
  typedef logic [31:0] ipv4_t;
  typedef logic [47:0] mac_t;
  typedef logic [15:0] port_t;
  typedef logic [15:0] len_t;   // byte length
  typedef logic [31:0] xid_t;   // transaction id

  ////////////////////////////////////////////////////////////
  // sizes
  ////////////////////////////////////////////////////////////

  localparam int DHCP_HDR_LEN   = 240;                         // incl. magic cookie
  localparam int OPT_LEN        = 16;                          // bytes per option slot
  localparam int OPT_NUM_TX     = 7;                           // slots, end slot included
  localparam int OPT_TOT_LEN_TX = OPT_LEN * OPT_NUM_TX;        // 112
  localparam int HDR_TOT_LEN_TX = DHCP_HDR_LEN + OPT_TOT_LEN_TX; // 352
  localparam int UDP_HDR_LEN    = 8;

  // option codes
  localparam byte_t DHCP_OPT_MESSAGE_TYPE                = 8'd53;
  localparam byte_t DHCP_OPT_REQUESTED_IP_ADDRESS        = 8'd50;
  localparam byte_t DHCP_OPT_DHCP_CLIENT_ID              = 8'd61;
  localparam byte_t DHCP_OPT_HOSTNAME                    = 8'd12;
  localparam byte_t DHCP_OPT_DOMAIN_NAME                 = 8'd15;
  localparam byte_t DHCP_OPT_FULLY_QUALIFIED_DOMAIN_NAME = 8'd81;
  localparam byte_t DHCP_OPT_PAD                         = 8'd0;
  localparam byte_t DHCP_OPT_END                         = 8'd255;

  // value lengths of the fixed-size options
  localparam int DHCP_OPT_MESSAGE_TYPE_LEN         = 1;
  localparam int DHCP_OPT_REQUESTED_IP_ADDRESS_LEN = 4;
  localparam int DHCP_OPT_DHCP_CLIENT_ID_LEN       = 7;  // htype + mac

  // fixed header field values
  localparam byte_t       DHCP_OP_BOOTREQUEST = 8'd1;
  localparam byte_t       DHCP_HTYPE_ETH      = 8'd1;
  localparam byte_t       DHCP_HLEN_ETH       = 8'd6;
  localparam logic [15:0] DHCP_FLAGS_BCAST    = 16'h8000;  // ask for broadcast reply
  localparam logic [31:0] DHCP_MAGIC_COOKIE   = 32'h6382_5363;

  // message types carried in option 53
  localparam byte_t DHCP_MSG_DISCOVER = 8'd1;
  localparam byte_t DHCP_MSG_REQUEST  = 8'd3;

  localparam port_t DHCP_CLI_PORT = 16'd68;
  localparam port_t DHCP_SRV_PORT = 16'd67;
  localparam mac_t  MAC_BROADCAST = 48'hffff_ffff_ffff;

  // ipv4 id generator
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
  localparam logic [31:0] LFSR_SEED = 32'h0000_0001;

  ////////////////////////////////////////////////////////////
  // composite types
  ////////////////////////////////////////////////////////////

  typedef logic [OPT_NUM_TX-2:0]        opt_pres_t;  // bit 0 = message type
  typedef logic [0:OPT_LEN-1][7:0]      opt_slot_t;  // code, len, value, pad
  typedef opt_slot_t [0:OPT_NUM_TX-1]   opt_area_t;  // first slot first

  typedef struct packed {
    byte_t     msg_type;
    xid_t      xid;
    mac_t      chaddr;
    ipv4_t     ciaddr;
    ipv4_t     req_ip;   // option 50 value
    ipv4_t     src_ip;
    ipv4_t     dst_ip;
    opt_pres_t opt_pres;
  } dhcp_req_t;

  // fixed bootp header, msb = first byte on the wire
  typedef struct packed {
    byte_t          op;
    byte_t          htype;
    byte_t          hlen;
    byte_t          hops;
    xid_t           xid;
    logic [15:0]    secs;
    logic [15:0]    flags;
    ipv4_t          ciaddr;
    ipv4_t          yiaddr;
    ipv4_t          siaddr;
    ipv4_t          giaddr;
    logic [127:0]   chaddr;     // mac + 10 zero bytes
    logic [511:0]   sname;
    logic [1023:0]  boot_file;
    logic [31:0]    cookie;
  } dhcp_hdr_t;

  typedef struct packed {
    port_t       src_port;
    port_t       dst_port;
    len_t        length;   // udp length, header included
    logic [15:0] cks;
    ipv4_t       src_ip;
    ipv4_t       dst_ip;
    logic [15:0] ipv4_id;
    mac_t        dst_mac;
  } udp_meta_t;

  typedef struct packed {
    byte_t dat;
    logic  val;
    logic  sof;
    logic  eof;
  } udp_strm_t;

endpackage
